// ==== mmu_settings.svh ====
//////////////////////////////
// Memory map boundaries and RAM sizing for the MMU
// Reset instruction presented on the instruction port
//////////////////////////////
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Byte address bits of the main RAM, 256 bytes
`define MMU_RAM_ADDR_BITS 8

// Depth of each byte lane
`define MMU_RAM_WORDS 64

// ROM region ends just below this address
`define MMU_ROM_LIMIT 32'h0000_1000

// Main RAM runs from here up to the I/O base
`define MMU_RAM_BASE 32'h1000_0000

// I/O window base and size in bytes
`define MMU_IO_BASE 32'h8000_0000
`define MMU_IO_SPAN 32'h0000_0100

// addi x0, x0, 0
`define MMU_RESET_INSN 32'h0000_0013

`endif

// ==== mmu_map_pkg.sv ====
//////////////////////////////
// Memory map types
//  - device enum
//  - decoded route of a data address
//////////////////////////////
`default_nettype none

`include "mmu_settings.svh"

package mmu_map_pkg;

   // Targets of a data-port access
   typedef enum logic [1:0] {
      DEV_NONE,
      DEV_ROM,
      DEV_RAM,
      DEV_IO
   } mmu_dev_e;

   // Result of the region decode
   typedef struct packed {
      mmu_dev_e                        dev;
      // Word index into the RAM lanes
      logic [`MMU_RAM_ADDR_BITS-3:0] word_idx;
      // Byte offset inside the I/O window
      logic [7:0]                      io_off;
   } mmu_route_t;

endpackage

`default_nettype wire

// ==== mmu_access_pkg.sv ====
//////////////////////////////
// Data-port access types
//  - request, I/O request, load control
//  - access width and its decode from the byte enable
//////////////////////////////
`default_nettype none

package mmu_access_pkg;

   typedef logic [3:0] mmu_be_t;

   typedef enum logic [1:0] {
      W_BYTE,
      W_HALF,
      W_WORD,
      W_BAD
   } mmu_width_e;

   // Request from the core, presented every cycle
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      mmu_be_t     be;
      logic        we;
      logic        is_signed;
   } mmu_dm_req_t;

   // Registered request to the I/O bank
   typedef struct packed {
      logic [7:0]  addr;
      logic [31:0] wdata;
      logic        en;
      logic        we;
   } mmu_io_req_t;

   // Load control held for the response cycle
   typedef struct packed {
      mmu_map_pkg::mmu_dev_e dev;
      mmu_be_t               be;
      logic                  is_signed;
   } mmu_load_ctl_t;

   // Only aligned bytes, halves and full words are legal
   function automatic mmu_width_e mmu_be_width(input mmu_be_t be);
      case (be)
         4'b0001, 4'b0010, 4'b0100, 4'b1000: return W_BYTE;
         4'b0011, 4'b1100:                   return W_HALF;
         4'b1111:                            return W_WORD;
         default:                            return W_BAD;
      endcase
   endfunction

endpackage

`default_nettype wire

// ==== mmu_addr_decode.sv ====
//////////////////////////////
// Data address region decoder
//  - ROM, main RAM, I/O window
//  - RAM word index and I/O offset
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "mmu_settings.svh"

module mmu_addr_decode (
   input  logic [31:0]             addr,
   output mmu_map_pkg::mmu_route_t route
);

   import mmu_map_pkg::*;

   logic [31:0] ram_off;
   logic [31:0] io_off;
   logic        in_rom;
   logic        in_ram;
   logic        in_io;

   // Offsets into each region
   assign ram_off = addr - `MMU_RAM_BASE;
   assign io_off  = addr - `MMU_IO_BASE;

   assign in_rom = (addr < `MMU_ROM_LIMIT);
   assign in_ram = (addr >= `MMU_RAM_BASE) && (addr < `MMU_IO_BASE);
   assign in_io  = (addr >= `MMU_IO_BASE) && (addr < (`MMU_IO_BASE + `MMU_IO_SPAN));

   always_comb begin
      // RAM aliases across the whole region, only the low bits count
      route.word_idx = ram_off[`MMU_RAM_ADDR_BITS-1:2];
      route.io_off   = io_off[7:0];

      // Priority order, anything else is unmapped
      if (in_rom) begin
         route.dev = DEV_ROM;
      end else if (in_ram) begin
         route.dev = DEV_RAM;
      end else if (in_io) begin
         route.dev = DEV_IO;
      end else begin
         route.dev = DEV_NONE;
      end
   end

endmodule

`default_nettype wire

// ==== mmu_store_align.sv ====
//////////////////////////////
// Store data lane alignment
//  - width from byte enable
//  - byte/half moved onto lanes
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mmu_store_align (
   input  logic [31:0]              wdata,
   input  mmu_access_pkg::mmu_be_t  be,
   output logic [31:0]              lane_wdata
);

   import mmu_access_pkg::*;

   mmu_width_e  width;
   logic [31:0] lane_mask;

   assign width = mmu_be_width(be);

   // One byte of mask per enabled lane
   assign lane_mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};

   always_comb begin
      case (width)
         W_WORD: begin
            lane_wdata = wdata;
         end
         W_HALF: begin
            // Low half copied to both halves, mask keeps the target
            lane_wdata = {2{wdata[15:0]}} & lane_mask;
         end
         W_BYTE: begin
            lane_wdata = {4{wdata[7:0]}} & lane_mask;
         end
         default: begin
            // Illegal enable
            lane_wdata = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== mmu_data_ram.sv ====
//////////////////////////////
// Main data RAM
//  - four interleaved byte lanes
//  - write-first, per-lane enable
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "mmu_settings.svh"

module mmu_data_ram (
   input  logic                          clk,
   input  logic [`MMU_RAM_ADDR_BITS-3:0] addr,
   input  logic                          we,
   input  mmu_access_pkg::mmu_be_t       be,
   input  logic [31:0]                   wdata,
   output logic [31:0]                   rdata
);

   genvar lane;

   for (lane = 0; lane < 4; lane++) begin : g_lane
      logic [7:0] mem [`MMU_RAM_WORDS];
      logic [7:0] dout;
      logic [7:0] din;

      assign din = wdata[lane*8 +: 8];

      // Lane idles and holds its output when not enabled
      always_ff @(posedge clk) begin
         if (be[lane]) begin
            if (we) begin
               mem[addr] <= din;
               // New data goes straight to the output
               dout      <= din;
            end else begin
               dout      <= mem[addr];
            end
         end
      end

      assign rdata[lane*8 +: 8] = dout;
   end

endmodule

`default_nettype wire

// ==== mmu_load_extend.sv ====
//////////////////////////////
// Load response path
//  - registered load control
//  - RAM / I/O source select
//  - lane extract, sign or zero extend
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mmu_load_extend (
   input  logic                     clk,
   input  logic                     resetb,
   input  mmu_map_pkg::mmu_dev_e    dev,
   input  mmu_access_pkg::mmu_be_t  be,
   input  logic                     is_signed,
   input  logic [31:0]              ram_rdata,
   input  logic [31:0]              io_rdata,
   output logic [31:0]              dm_do
);

   import mmu_map_pkg::*;
   import mmu_access_pkg::*;

   mmu_load_ctl_t ctl_q;
   mmu_width_e    width;
   logic [31:0]   src;
   logic [15:0]   half_val;
   logic [7:0]    byte_val;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         ctl_q <= '{dev: DEV_NONE, be: '0, is_signed: 1'b0};
      end else begin
         ctl_q <= '{dev: dev, be: be, is_signed: is_signed};
      end
   end

   assign width = mmu_be_width(ctl_q.be);

   // ROM and unmapped reads return zero
   always_comb begin
      case (ctl_q.dev)
         DEV_RAM: src = ram_rdata;
         DEV_IO:  src = io_rdata;
         default: src = '0;
      endcase
   end

   assign half_val = ctl_q.be[2] ? src[31:16] : src[15:0];

   always_comb begin
      case (ctl_q.be)
         4'b0010: byte_val = src[15:8];
         4'b0100: byte_val = src[23:16];
         4'b1000: byte_val = src[31:24];
         default: byte_val = src[7:0];
      endcase
   end

   always_comb begin
      case (width)
         W_WORD:  dm_do = src;
         W_HALF:  dm_do = {{16{ctl_q.is_signed & half_val[15]}}, half_val};
         W_BYTE:  dm_do = {{24{ctl_q.is_signed & byte_val[7]}}, byte_val};
         default: dm_do = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== mmu_io_port.sv ====
//////////////////////////////
// I/O bank request registers
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mmu_io_port (
   input  logic                         clk,
   input  logic                         resetb,
   input  mmu_map_pkg::mmu_route_t      route,
   input  logic                         we,
   input  logic [31:0]                  lane_wdata,
   output mmu_access_pkg::mmu_io_req_t  io_req
);

   import mmu_map_pkg::*;

   logic        io_hit;
   logic        en_q;
   logic        we_q;
   logic [7:0]  addr_q;
   logic [31:0] wdata_q;

   assign io_hit = (route.dev == DEV_IO);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         en_q <= 1'b0;
         we_q <= 1'b0;
      end else begin
         en_q <= io_hit;
         we_q <= io_hit & we;
      end
   end

   always_ff @(posedge clk) begin
      addr_q  <= route.io_off;
      wdata_q <= lane_wdata;
   end

   assign io_req = '{addr: addr_q, wdata: wdata_q, en: en_q, we: we_q};

endmodule

`default_nettype wire

// ==== mmu.sv ====
//////////////////////////////
// MMU top level
//  - instruction port and register
//  - data port decode, RAM, I/O
//  - load response path
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "mmu_settings.svh"

module mmu (
   input  logic                         clk,
   input  logic                         resetb,
   input  logic [31:0]                  im_addr,
   input  logic [31:0]                  im_data,
   output logic [11:2]                  im_addr_out,
   output logic [31:0]                  im_do,
   input  mmu_access_pkg::mmu_dm_req_t  dm_req,
   output logic [31:0]                  dm_do,
   input  logic [31:0]                  io_data_read,
   output mmu_access_pkg::mmu_io_req_t  io_req
);

   import mmu_map_pkg::*;
   import mmu_access_pkg::*;

   mmu_route_t  route;
   logic [31:0] lane_wdata;
   logic [31:0] ram_rdata;
   logic        store_ok;
   logic        ram_we;

   // ROM is word addressed
   assign im_addr_out = im_addr[11:2];

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         im_do <= `MMU_RESET_INSN;
      end else begin
         im_do <= im_data;
      end
   end

   // Illegal enables never write
   assign store_ok = dm_req.we && (mmu_be_width(dm_req.be) != W_BAD);
   assign ram_we   = store_ok && (route.dev == DEV_RAM);

   mmu_addr_decode u_addr_decode (
      .addr  (dm_req.addr),
      .route (route)
   );

   mmu_store_align u_store_align (
      .wdata      (dm_req.wdata),
      .be         (dm_req.be),
      .lane_wdata (lane_wdata)
   );

   mmu_data_ram u_data_ram (
      .clk   (clk),
      .addr  (route.word_idx),
      .we    (ram_we),
      .be    (dm_req.be),
      .wdata (lane_wdata),
      .rdata (ram_rdata)
   );

   mmu_io_port u_io_port (
      .clk        (clk),
      .resetb     (resetb),
      .route      (route),
      .we         (store_ok),
      .lane_wdata (lane_wdata),
      .io_req     (io_req)
   );

   mmu_load_extend u_load_extend (
      .clk       (clk),
      .resetb    (resetb),
      .dev       (route.dev),
      .be        (dm_req.be),
      .is_signed (dm_req.is_signed),
      .ram_rdata (ram_rdata),
      .io_rdata  (io_data_read),
      .dm_do     (dm_do)
   );

endmodule

`default_nettype wire

// ==== mmu_tb.sv ====
//////////////////////////////
// Random self-checking testbench for the MMU
//  - byte-array model of the RAM
//  - random I/O responder
//  - region, alias and I/O checks
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "mmu_settings.svh"

module mmu_tb;

   import mmu_map_pkg::*;
   import mmu_access_pkg::*;

   localparam int N_FILL  = 64;
   localparam int N_STORE = 200;
   localparam int N_ALIAS = 100;
   localparam int N_IO    = 100;
   localparam int N_UNMAP = 60;
   localparam int PLANNED = 6 + N_FILL + 3 * N_STORE + 2 * N_ALIAS + N_IO + 2 * N_UNMAP;
   localparam int CYCLE_LIMIT = 4 * PLANNED;

   logic        clk;
   logic        resetb;
   logic [31:0] im_addr;
   logic [31:0] im_data;
   logic [11:2] im_addr_out;
   logic [31:0] im_do;
   mmu_dm_req_t dm_req;
   logic [31:0] dm_do;
   logic [31:0] io_data_read;
   mmu_io_req_t io_req;

   // Model state
   logic [7:0]  model_mem [256];
   logic [31:0] prev_im;
   mmu_dev_e    pend_dev;
   mmu_be_t     pend_be;
   logic        pend_sgn;
   logic [31:0] pend_word;
   logic [7:0]  pend_io_addr;
   logic [31:0] pend_io_wdata;
   logic        pend_io_we;

   int          errors;
   int          test_errors;
   int          tests_run;
   int          tests_failed;
   int          cycle_count;

   mmu u_mmu (
      .clk          (clk),
      .resetb       (resetb),
      .im_addr      (im_addr),
      .im_data      (im_data),
      .im_addr_out  (im_addr_out),
      .im_do        (im_do),
      .dm_req       (dm_req),
      .dm_do        (dm_do),
      .io_data_read (io_data_read),
      .io_req       (io_req)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Run stopped, no end of test after %0d cycles", cycle_count);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // Region boundaries of the memory map
   function automatic mmu_dev_e region_of(input logic [31:0] a);
      if (a < `MMU_ROM_LIMIT) begin
         return DEV_ROM;
      end
      if (a >= `MMU_RAM_BASE && a < `MMU_IO_BASE) begin
         return DEV_RAM;
      end
      if (a >= `MMU_IO_BASE && (a - `MMU_IO_BASE) < `MMU_IO_SPAN) begin
         return DEV_IO;
      end
      return DEV_NONE;
   endfunction

   function automatic logic be_legal(input mmu_be_t be);
      return (be == 4'b0001) || (be == 4'b0010) || (be == 4'b0100) || (be == 4'b1000) ||
             (be == 4'b0011) || (be == 4'b1100) || (be == 4'b1111);
   endfunction

   // Store data as it lands on the lanes
   function automatic logic [31:0] store_lanes(input logic [31:0] wdata, input mmu_be_t be);
      logic [31:0] res;
      res = '0;
      for (int i = 0; i < 4; i++) begin
         if (be[i]) begin
            if (be == 4'b1111) res[i*8 +: 8] = wdata[i*8 +: 8];
            else if (be == 4'b0011 || be == 4'b1100) res[i*8 +: 8] = wdata[(i%2)*8 +: 8];
            else res[i*8 +: 8] = wdata[7:0];
         end
      end
      return be_legal(be) ? res : 32'h0;
   endfunction

   // Picks the enabled lanes out of a word and extends them
   function automatic logic [31:0] load_value(input logic [31:0] w, input mmu_be_t be,
                                              input logic sgn);
      logic [15:0] h;
      logic [7:0]  b;
      if (be == 4'b1111) return w;
      if (be == 4'b0011 || be == 4'b1100) begin
         h = (be == 4'b1100) ? w[31:16] : w[15:0];
         return {{16{sgn & h[15]}}, h};
      end
      for (int i = 0; i < 4; i++) begin
         if (be == (4'b0001 << i)) begin
            b = w[i*8 +: 8];
            return {{24{sgn & b[7]}}, b};
         end
      end
      return 32'h0;
   endfunction

   function automatic mmu_be_t pick_be();
      logic [1:0] pos;
      pos = 2'($urandom % 4);
      case ($urandom % 3)
         0: return mmu_be_t'(4'b0001 << pos);
         1: return pos[1] ? 4'b1100 : 4'b0011;
         default: return 4'b1111;
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors = errors + 1;
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
   endtask

   // Response of the request captured at the last rising edge
   task automatic check_response();
      logic [31:0] exp_do;
      case (pend_dev)
         DEV_RAM: exp_do = load_value(pend_word, pend_be, pend_sgn);
         DEV_IO:  exp_do = load_value(io_data_read, pend_be, pend_sgn);
         default: exp_do = 32'h0;
      endcase
      if (dm_do !== exp_do) report_mismatch("dm_do", dm_do, exp_do);
      if (im_do !== prev_im) report_mismatch("im_do", im_do, prev_im);
      if (im_addr_out !== im_addr[11:2]) report_mismatch("im_addr_out", 32'(im_addr_out),
                                                          32'(im_addr[11:2]));
      if (io_req.en !== (pend_dev == DEV_IO)) begin
         report_mismatch("io_req.en", 32'(io_req.en), 32'(pend_dev == DEV_IO));
      end
      if (pend_dev == DEV_IO) begin
         if (io_req.we !== pend_io_we) report_mismatch("io_req.we", 32'(io_req.we),
                                                        32'(pend_io_we));
         if (io_req.addr !== pend_io_addr) report_mismatch("io_req.addr", 32'(io_req.addr),
                                                            32'(pend_io_addr));
         if (io_req.wdata !== pend_io_wdata) report_mismatch("io_req.wdata", io_req.wdata,
                                                              pend_io_wdata);
      end else if (io_req.we !== 1'b0) begin
         report_mismatch("io_req.we", 32'(io_req.we), 32'h0);
      end
   endtask

   // Drives one request and checks the response of the previous one
   task automatic run_cycle(input logic [31:0] addr, input logic [31:0] wdata,
                            input mmu_be_t be, input logic we, input logic sgn);
      logic [31:0] lanes;
      @(posedge clk);
      #2;
      dm_req.addr      = addr;
      dm_req.wdata     = wdata;
      dm_req.be        = be;
      dm_req.we        = we;
      dm_req.is_signed = sgn;
      im_addr          = $urandom;
      im_data          = $urandom;
      io_data_read     = $urandom;
      @(negedge clk);
      check_response();
      prev_im  = im_data;
      lanes    = store_lanes(wdata, be);
      pend_dev = region_of(addr);
      pend_be  = be;
      pend_sgn = sgn;
      // Write-first lanes return the new bytes on the store cycle
      if (pend_dev == DEV_RAM && we && be_legal(be)) begin
         for (int i = 0; i < 4; i++) begin
            if (be[i]) model_mem[{addr[7:2], 2'(i)}] = lanes[i*8 +: 8];
         end
      end
      for (int i = 0; i < 4; i++) begin
         pend_word[i*8 +: 8] = model_mem[{addr[7:2], 2'(i)}];
      end
      pend_io_addr  = addr[7:0];
      pend_io_wdata = lanes;
      pend_io_we    = we && be_legal(be);
   endtask

   task automatic start_test();
      test_errors = errors;
   endtask

   task automatic finish_test(input string name);
      tests_run = tests_run + 1;
      if (errors == test_errors) begin
         $display("test %s: pass", name);
      end else begin
         tests_failed = tests_failed + 1;
         $display("test %s: fail, %0d errors", name, errors - test_errors);
      end
   endtask

   initial begin
      logic [31:0] a;
      logic [31:0] off;
      mmu_be_t     be;
      resetb       = 1'b0;
      im_addr      = '0;
      im_data      = '0;
      io_data_read = '0;
      dm_req       = '0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      cycle_count  = 0;
      prev_im      = '0;
      pend_dev     = DEV_NONE;
      pend_be      = '0;
      pend_sgn     = 1'b0;
      pend_word    = '0;
      void'($urandom(66));

      start_test();
      repeat (4) @(posedge clk);
      #2;
      resetb = 1'b1;
      @(negedge clk);
      if (im_do !== `MMU_RESET_INSN) report_mismatch("im_do", im_do, `MMU_RESET_INSN);
      if (io_req.en !== 1'b0) report_mismatch("io_req.en", 32'(io_req.en), 32'h0);
      if (io_req.we !== 1'b0) report_mismatch("io_req.we", 32'(io_req.we), 32'h0);
      if (dm_do !== 32'h0) report_mismatch("dm_do", dm_do, 32'h0);
      finish_test("reset");

      // Word stores fill every RAM word first
      start_test();
      for (int k = 0; k < N_FILL; k++) begin
         run_cycle(`MMU_RAM_BASE + 32'(k * 4), $urandom, 4'b1111, 1'b1, 1'b0);
      end
      for (int k = 0; k < N_STORE; k++) begin
         a  = `MMU_RAM_BASE + ($urandom % 256);
         be = (($urandom % 16) == 0) ? mmu_be_t'($urandom) : pick_be();
         run_cycle(a, $urandom, be, 1'b1, 1'($urandom));
         run_cycle(a, $urandom, pick_be(), 1'b0, 1'($urandom));
         run_cycle(a, $urandom, pick_be(), 1'b0, 1'($urandom));
      end
      finish_test("ram_store_load");

      start_test();
      for (int k = 0; k < N_ALIAS; k++) begin
         a   = `MMU_RAM_BASE + ($urandom % 32'h7000_0000);
         off = $urandom % 32'h7000_0000;
         run_cycle(a, $urandom, pick_be(), 1'b1, 1'($urandom));
         run_cycle(`MMU_RAM_BASE + {off[31:8], a[7:0]}, $urandom, pick_be(), 1'b0,
                   1'($urandom));
      end
      finish_test("ram_alias");

      start_test();
      for (int k = 0; k < N_IO; k++) begin
         run_cycle(`MMU_IO_BASE + ($urandom % 256), $urandom, pick_be(), 1'($urandom),
                   1'($urandom));
      end
      finish_test("io_access");

      // ROM and unmapped stores must leave the RAM alone
      start_test();
      for (int k = 0; k < N_UNMAP; k++) begin
         case ($urandom % 3)
            0: a = $urandom % `MMU_ROM_LIMIT;
            1: a = `MMU_ROM_LIMIT + ($urandom % (`MMU_RAM_BASE - `MMU_ROM_LIMIT));
            default: a = `MMU_IO_BASE + `MMU_IO_SPAN +
                         ($urandom % (32'hFFFF_FFFF - `MMU_IO_BASE - `MMU_IO_SPAN));
         endcase
         run_cycle(a, $urandom, pick_be(), 1'b1, 1'($urandom));
         run_cycle(`MMU_RAM_BASE + a[7:0], $urandom, 4'b1111, 1'b0, 1'b0);
      end
      run_cycle(32'h0, 32'h0, 4'b0000, 1'b0, 1'b0);
      finish_test("rom_unmapped");

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
               errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
mmu_map_pkg.sv
mmu_access_pkg.sv
mmu_addr_decode.sv
mmu_store_align.sv
mmu_data_ram.sv
mmu_load_extend.sv
mmu_io_port.sv
mmu.sv
mmu_tb.sv

// ==== Bender.yml ====
package:
  name: mmu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mmu_map_pkg.sv
      - mmu_access_pkg.sv
      - mmu_addr_decode.sv
      - mmu_store_align.sv
      - mmu_data_ram.sv
      - mmu_load_extend.sv
      - mmu_io_port.sv
      - mmu.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - mmu_tb.sv
